//--- proxy_pkg.sv
package proxy_pkg;

    // --------------------
    // Bus widths
    // --------------------
    localparam int APB_ADDR_WID = 12;
    localparam int APB_DATA_WID = 32;

    // Byte offset inside one region window
    localparam int OFFSET_WID = 8;

    // --------------------
    // Region map
    // --------------------
    // Address bits 11:10 select the region
    typedef enum logic [1:0] {
        REGION_REG   = 2'd0,
        REGION_MEM   = 2'd1,
        REGION_RSVD2 = 2'd2,
        REGION_RSVD3 = 2'd3
    } region_e;

    // Register proxy window
    localparam int REG_OFS_CMD    = 'h00;
    localparam int REG_OFS_WDATA  = 'h04;
    localparam int REG_OFS_RDATA  = 'h08;
    localparam int REG_OFS_STATUS = 'h0C;

    // Memory proxy window
    localparam int MEM_OFS_ADDR    = 'h00;
    localparam int MEM_OFS_DATA_LO = 'h04;
    localparam int MEM_OFS_DATA_HI = 'h08;
    localparam int MEM_OFS_CMD     = 'h0C;

    // --------------------
    // Inner register file
    // --------------------
    localparam int INNER_IDX_WID = 3;
    localparam int IDX_PRE       = 0;
    localparam int IDX_POST      = 1;
    localparam int IDX_TRIGGER   = 2;
    localparam int IDX_STATUS    = 3;

    localparam logic [31:0] ID_PRE  = 32'h2050_5245;  // " PRE"
    localparam logic [31:0] ID_POST = 32'h504F_5354;  // "POST"

    // Read command to valid data, in cycles
    localparam int MEM_RD_LATENCY = 2;

endpackage : proxy_pkg

//--- proxy_bus_if.sv
`timescale 1ns/1ps

// One request/response channel from the APB decoder to a proxy.
// req is held until ready, ready is a single-cycle pulse.
interface proxy_bus_if;

    // Request, driven by the decoder
    logic                                 req;
    logic                                 write;
    logic [proxy_pkg::OFFSET_WID-1:0]     offset;
    logic [proxy_pkg::APB_DATA_WID-1:0]   wdata;

    // Response, valid while ready is high
    logic [proxy_pkg::APB_DATA_WID-1:0]   rdata;
    logic                                 ready;
    logic                                 err;

    modport host (
        output req,
        output write,
        output offset,
        output wdata,
        input  rdata,
        input  ready,
        input  err
    );

    modport target (
        input  req,
        input  write,
        input  offset,
        input  wdata,
        output rdata,
        output ready,
        output err
    );

endinterface : proxy_bus_if

//--- proxy_apb_decoder.sv
`timescale 1ns/1ps

module proxy_apb_decoder (
    input  logic                                clk,
    input  logic                                srst,

    input  logic                                i_psel,
    input  logic                                i_penable,
    input  logic                                i_pwrite,
    input  logic [proxy_pkg::APB_ADDR_WID-1:0]  i_paddr,
    input  logic [proxy_pkg::APB_DATA_WID-1:0]  i_pwdata,
    output logic [proxy_pkg::APB_DATA_WID-1:0]  o_prdata,
    output logic                                o_pready,
    output logic                                o_pslverr,

    proxy_bus_if.host                           reg_bus,
    proxy_bus_if.host                           mem_bus
);

    proxy_pkg::region_e region;
    logic               access;
    logic               sel_reg;
    logic               sel_mem;
    logic               unmapped;
    logic               done_q;

    // --------------------
    // Region decode
    // --------------------
    assign region = proxy_pkg::region_e'(i_paddr[proxy_pkg::APB_ADDR_WID-1 -: 2]);

    // Access phase masked in the cycle right after a completion
    assign access = i_psel && i_penable && !done_q;

    always_comb begin
        sel_reg  = 1'b0;
        sel_mem  = 1'b0;
        unmapped = 1'b0;
        case (region)
            proxy_pkg::REGION_REG:   sel_reg  = access;
            proxy_pkg::REGION_MEM:   sel_mem  = access;
            proxy_pkg::REGION_RSVD2: unmapped = access;
            proxy_pkg::REGION_RSVD3: unmapped = access;
            default:                 unmapped = access;
        endcase
    end

    always_ff @(posedge clk) begin
        if (srst) begin
            done_q <= 1'b0;
        end else begin
            done_q <= o_pready;
        end
    end

    // --------------------
    // Requests to proxies
    // --------------------
    assign reg_bus.req    = sel_reg;
    assign reg_bus.write  = i_pwrite;
    assign reg_bus.offset = i_paddr[proxy_pkg::OFFSET_WID-1:0];
    assign reg_bus.wdata  = i_pwdata;

    assign mem_bus.req    = sel_mem;
    assign mem_bus.write  = i_pwrite;
    assign mem_bus.offset = i_paddr[proxy_pkg::OFFSET_WID-1:0];
    assign mem_bus.wdata  = i_pwdata;

    // --------------------
    // Response merge
    // --------------------
    // Unmapped regions answer at once with zero data
    assign o_pready  = unmapped || reg_bus.ready || mem_bus.ready;

    // Proxies raise err only in their ready cycle
    assign o_pslverr = unmapped || reg_bus.err || mem_bus.err;

    always_comb begin
        o_prdata = '0;
        if (reg_bus.ready) begin
            o_prdata = reg_bus.rdata;
        end else if (mem_bus.ready) begin
            o_prdata = mem_bus.rdata;
        end
    end

endmodule : proxy_apb_decoder

//--- reg_proxy.sv
`timescale 1ns/1ps

module reg_proxy (
    input  logic        clk,
    input  logic        srst,
    proxy_bus_if.target bus
);

    localparam int DATA_WID    = proxy_pkg::APB_DATA_WID;
    localparam int IDX_WID     = proxy_pkg::INNER_IDX_WID;
    localparam int CMD_WR_BIT  = 8;
    localparam int NUM_SCRATCH = 4;
    localparam int SCR_SEL_WID = $clog2(NUM_SCRATCH);

    logic                accept;
    logic                inner_go;
    logic                cmd_wr;
    logic [IDX_WID-1:0]  cmd_idx;
    logic                inner_wr_bad;
    logic [DATA_WID-1:0] inner_rd_val;
    logic [DATA_WID-1:0] win_rd_val;
    logic                win_err;

    logic [DATA_WID-1:0] cmd_q;
    logic [DATA_WID-1:0] wdata_q;
    logic [DATA_WID-1:0] rdata_q;
    logic                sticky_err_q;

    logic [DATA_WID-1:0] trigger_q;
    logic [DATA_WID-1:0] status_q;
    logic [DATA_WID-1:0] scratch_q [NUM_SCRATCH];

    assign accept  = bus.req && !bus.ready;
    assign cmd_wr  = bus.wdata[CMD_WR_BIT];
    assign cmd_idx = bus.wdata[IDX_WID-1:0];

    // A write to CMD runs one inner access
    assign inner_go = accept && bus.write && (int'(bus.offset) == proxy_pkg::REG_OFS_CMD);

    // Identity words and captured status are not writable
    assign inner_wr_bad = (int'(cmd_idx) == proxy_pkg::IDX_PRE)
                       || (int'(cmd_idx) == proxy_pkg::IDX_POST)
                       || (int'(cmd_idx) == proxy_pkg::IDX_STATUS);

    // --------------------
    // Inner read mux
    // --------------------
    always_comb begin
        case (int'(cmd_idx))
            proxy_pkg::IDX_PRE:     inner_rd_val = proxy_pkg::ID_PRE;
            proxy_pkg::IDX_POST:    inner_rd_val = proxy_pkg::ID_POST;
            proxy_pkg::IDX_TRIGGER: inner_rd_val = trigger_q;
            proxy_pkg::IDX_STATUS:  inner_rd_val = status_q;
            default:                inner_rd_val = scratch_q[cmd_idx[SCR_SEL_WID-1:0]];
        endcase
    end

    // Window read mux and offset check
    always_comb begin
        win_rd_val = '0;
        win_err    = 1'b0;
        case (int'(bus.offset))
            proxy_pkg::REG_OFS_CMD:    win_rd_val = cmd_q;
            proxy_pkg::REG_OFS_WDATA:  win_rd_val = wdata_q;
            proxy_pkg::REG_OFS_RDATA:  win_rd_val = rdata_q;
            proxy_pkg::REG_OFS_STATUS: win_rd_val = DATA_WID'(sticky_err_q);
            default:                   win_err    = 1'b1;
        endcase
    end

    // --------------------
    // Window control
    // --------------------
    always_ff @(posedge clk) begin
        if (srst) begin
            bus.ready    <= 1'b0;
            bus.err      <= 1'b0;
            cmd_q        <= '0;
            sticky_err_q <= 1'b0;
        end else begin
            bus.ready <= accept;
            bus.err   <= accept && win_err;
            if (inner_go) begin
                cmd_q <= bus.wdata;
            end
            // Sticky error, cleared by any STATUS write
            if (inner_go && cmd_wr && inner_wr_bad) begin
                sticky_err_q <= 1'b1;
            end else if (accept && bus.write
                         && (int'(bus.offset) == proxy_pkg::REG_OFS_STATUS)) begin
                sticky_err_q <= 1'b0;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (accept && bus.write && (int'(bus.offset) == proxy_pkg::REG_OFS_WDATA)) begin
            wdata_q <= bus.wdata;
        end
        if (inner_go && !cmd_wr) begin
            rdata_q <= inner_rd_val;
        end
        bus.rdata <= win_rd_val;
    end

    // --------------------
    // Inner register file
    // --------------------
    always_ff @(posedge clk) begin
        if (srst) begin
            trigger_q <= '0;
            status_q  <= '0;
            scratch_q <= '{default: '0};
        end else if (inner_go && cmd_wr) begin
            if (int'(cmd_idx) == proxy_pkg::IDX_TRIGGER) begin
                trigger_q <= wdata_q;
                // Status follows every trigger write
                status_q  <= wdata_q;
            end else if (cmd_idx[IDX_WID-1]) begin
                scratch_q[cmd_idx[SCR_SEL_WID-1:0]] <= wdata_q;
            end
        end
    end

endmodule : reg_proxy

//--- mem_proxy.sv
`timescale 1ns/1ps

module mem_proxy #(
    parameter int MEM_DEPTH    = 512,
    parameter int MEM_DATA_WID = 64
) (
    input  logic        clk,
    input  logic        srst,
    proxy_bus_if.target bus
);

    localparam int ADDR_WID   = $clog2(MEM_DEPTH);
    localparam int WORD_WID   = proxy_pkg::APB_DATA_WID;
    localparam bit HAS_HI     = (MEM_DATA_WID > WORD_WID);
    localparam int CNT_WID    = $clog2(proxy_pkg::MEM_RD_LATENCY + 2);
    localparam int CMD_WR_BIT = 0;
    localparam int CMD_RD_BIT = 1;

    logic [MEM_DATA_WID-1:0] mem [MEM_DEPTH];
    logic [MEM_DATA_WID-1:0] ram_q;
    logic [MEM_DATA_WID-1:0] data_q;
    logic [ADDR_WID-1:0]     addr_q;
    logic [ADDR_WID-1:0]     addr_nxt;
    logic [CNT_WID-1:0]      rd_cnt_q;
    logic                    busy;
    logic                    hold;
    logic                    accept;
    logic                    mem_wr;
    logic                    mem_rd;
    logic [WORD_WID-1:0]     rd_val;
    logic                    win_err;

    assign busy = (rd_cnt_q != '0);

    // CMD and DATA wait while a read is in flight, ADDR does not
    assign hold = busy && (int'(bus.offset) != proxy_pkg::MEM_OFS_ADDR);

    assign accept = bus.req && !bus.ready && !hold;

    // Word address wraps at the top of the RAM
    assign addr_nxt = (addr_q == ADDR_WID'(MEM_DEPTH - 1)) ? '0 : addr_q + 1'b1;

    // --------------------
    // Window decode
    // --------------------
    always_comb begin
        rd_val  = '0;
        win_err = 1'b0;
        mem_wr  = 1'b0;
        mem_rd  = 1'b0;
        case (int'(bus.offset))
            proxy_pkg::MEM_OFS_ADDR:    rd_val = WORD_WID'(addr_q);
            proxy_pkg::MEM_OFS_DATA_LO: rd_val = data_q[WORD_WID-1:0];
            proxy_pkg::MEM_OFS_DATA_HI: begin
                if (HAS_HI) begin
                    rd_val = data_q[MEM_DATA_WID-1 -: WORD_WID];
                end else begin
                    win_err = 1'b1;
                end
            end
            proxy_pkg::MEM_OFS_CMD: begin
                if (bus.write) begin
                    if (bus.wdata[CMD_WR_BIT] && bus.wdata[CMD_RD_BIT]) begin
                        win_err = 1'b1;
                    end else begin
                        mem_wr = accept && bus.wdata[CMD_WR_BIT];
                        mem_rd = accept && bus.wdata[CMD_RD_BIT];
                    end
                end
            end
            default: win_err = 1'b1;
        endcase
    end

    // --------------------
    // Control
    // --------------------
    always_ff @(posedge clk) begin
        if (srst) begin
            bus.ready <= 1'b0;
            bus.err   <= 1'b0;
            addr_q    <= '0;
            rd_cnt_q  <= '0;
        end else begin
            bus.ready <= accept;
            bus.err   <= accept && win_err;
            if (accept && bus.write && (int'(bus.offset) == proxy_pkg::MEM_OFS_ADDR)) begin
                addr_q <= bus.wdata[ADDR_WID-1:0];
            end else if (mem_wr || mem_rd) begin
                addr_q <= addr_nxt;
            end
            // Busy covers the ready cycle plus MEM_RD_LATENCY cycles
            if (mem_rd) begin
                rd_cnt_q <= CNT_WID'(proxy_pkg::MEM_RD_LATENCY + 1);
            end else if (busy) begin
                rd_cnt_q <= rd_cnt_q - 1'b1;
            end
        end
    end

    // RAM with registered read port
    always_ff @(posedge clk) begin
        if (mem_wr) begin
            mem[addr_q] <= data_q;
        end
        if (mem_rd) begin
            ram_q <= mem[addr_q];
        end
    end

    // --------------------
    // Data registers
    // --------------------
    always_ff @(posedge clk) begin
        if (rd_cnt_q == CNT_WID'(1)) begin
            data_q <= ram_q;
        end else if (accept && bus.write) begin
            if (int'(bus.offset) == proxy_pkg::MEM_OFS_DATA_LO) begin
                data_q[WORD_WID-1:0] <= bus.wdata;
            end
            if (HAS_HI && (int'(bus.offset) == proxy_pkg::MEM_OFS_DATA_HI)) begin
                data_q[MEM_DATA_WID-1 -: WORD_WID] <= bus.wdata;
            end
        end
        bus.rdata <= rd_val;
    end

endmodule : mem_proxy

//--- proxy_test_top.sv
`timescale 1ns/1ps

module proxy_test_top #(
    parameter int MEM_DEPTH    = 512,
    parameter int MEM_DATA_WID = 64
) (
    input  logic                                clk,
    input  logic                                srst,

    // APB target port
    input  logic                                i_psel,
    input  logic                                i_penable,
    input  logic                                i_pwrite,
    input  logic [proxy_pkg::APB_ADDR_WID-1:0]  i_paddr,
    input  logic [proxy_pkg::APB_DATA_WID-1:0]  i_pwdata,
    output logic [proxy_pkg::APB_DATA_WID-1:0]  o_prdata,
    output logic                                o_pready,
    output logic                                o_pslverr
);

    proxy_bus_if reg_bus_if ();
    proxy_bus_if mem_bus_if ();

    // --------------------
    // APB decoder
    // --------------------
    proxy_apb_decoder i_proxy_apb_decoder (
        .clk       ( clk ),
        .srst      ( srst ),
        .i_psel    ( i_psel ),
        .i_penable ( i_penable ),
        .i_pwrite  ( i_pwrite ),
        .i_paddr   ( i_paddr ),
        .i_pwdata  ( i_pwdata ),
        .o_prdata  ( o_prdata ),
        .o_pready  ( o_pready ),
        .o_pslverr ( o_pslverr ),
        .reg_bus   ( reg_bus_if ),
        .mem_bus   ( mem_bus_if )
    );

    // --------------------
    // Proxies
    // --------------------
    reg_proxy i_reg_proxy (
        .clk  ( clk ),
        .srst ( srst ),
        .bus  ( reg_bus_if )
    );

    mem_proxy #(
        .MEM_DEPTH    ( MEM_DEPTH ),
        .MEM_DATA_WID ( MEM_DATA_WID )
    ) i_mem_proxy (
        .clk  ( clk ),
        .srst ( srst ),
        .bus  ( mem_bus_if )
    );

endmodule : proxy_test_top

//--- tb_clk_gen.sv
`timescale 1ns/1ps

module tb_clk_gen #(
    parameter int PERIOD_NS  = 100,
    parameter int RST_CYCLES = 8
) (
    output logic o_clk,
    output logic o_srst
);

    initial begin
        o_clk = 1'b0;
        forever #(PERIOD_NS / 2) o_clk = ~o_clk;
    end

    // Reset released on a falling edge, away from the sampling edge
    initial begin
        o_srst = 1'b1;
        repeat (RST_CYCLES) @(posedge o_clk);
        @(negedge o_clk);
        o_srst = 1'b0;
    end

endmodule : tb_clk_gen

//--- proxy_test_properties.sv
`timescale 1ns/1ps

module proxy_test_properties (
    input logic clk,
    input logic srst,
    input logic i_psel,
    input logic i_penable,
    input logic i_pready,
    input logic i_pslverr
);

    int fail_cnt = 0;

    // Ready only inside an access phase
    a_ready_in_access: assert property (@(posedge clk) disable iff (srst)
        i_pready |-> (i_psel && i_penable))
        else begin
            fail_cnt++;
            $error("pready high outside an APB access phase");
        end

    a_err_with_ready: assert property (@(posedge clk) disable iff (srst)
        i_pslverr |-> i_pready)
        else begin
            fail_cnt++;
            $error("pslverr high without pready");
        end

    // Quiet from the first reset edge through the cycle after reset
    a_quiet_after_reset: assert property (@(posedge clk) srst |=> !i_pready)
        else begin
            fail_cnt++;
            $error("pready high during reset or in the cycle after it");
        end

endmodule : proxy_test_properties

bind proxy_test_top proxy_test_properties props_i (
    .clk       ( clk ),
    .srst      ( srst ),
    .i_psel    ( i_psel ),
    .i_penable ( i_penable ),
    .i_pready  ( o_pready ),
    .i_pslverr ( o_pslverr )
);

//--- proxy_test_tb.sv
`timescale 1ns/1ps

module proxy_test_tb;

    localparam int MEM_DEPTH       = 512;
    localparam int MEM_DATA_WID    = 64;
    localparam int ADDR_WID        = proxy_pkg::APB_ADDR_WID;
    localparam int DATA_WID        = proxy_pkg::APB_DATA_WID;
    localparam bit HAS_HI          = (MEM_DATA_WID > DATA_WID);
    localparam int RST_CYCLES      = 8;
    localparam int CYCLES_PER_TEST = 40;
    localparam int N_WORDS         = 4;
    localparam int MEM_START       = 16;
    localparam int SCRATCH_IDX     = 5;

    localparam logic [ADDR_WID-1:0] REG_BASE = ADDR_WID'(proxy_pkg::REGION_REG) << 10;
    localparam logic [ADDR_WID-1:0] MEM_BASE = ADDR_WID'(proxy_pkg::REGION_MEM) << 10;
    localparam logic [DATA_WID-1:0] INNER_WR   = 32'h0000_0100;
    localparam logic [DATA_WID-1:0] MEM_CMD_WR = 32'd1;
    localparam logic [DATA_WID-1:0] MEM_CMD_RD = 32'd2;
    localparam logic [31:0]         LFSR_SEED  = 32'd91091;
    localparam logic [31:0]         LFSR_TAPS  = 32'h8020_0003;

    typedef struct {
        string               name;
        logic [ADDR_WID-1:0] addr;
        logic                write;
        logic [DATA_WID-1:0] wdata;
        logic                chk_data;
        logic [DATA_WID-1:0] exp_rdata;
        logic                exp_err;
    } test_t;

    logic                clk;
    logic                srst;
    logic                psel;
    logic                penable;
    logic                pwrite;
    logic [ADDR_WID-1:0] paddr;
    logic [DATA_WID-1:0] pwdata;
    logic [DATA_WID-1:0] prdata;
    logic                pready;
    logic                pslverr;
    test_t               tests_q [$];
    logic [31:0]         lfsr_state;
    int                  cycle_cnt = 0;
    int                  cycle_limit = 0;

    tb_clk_gen #(
        .PERIOD_NS  ( 100 ),
        .RST_CYCLES ( RST_CYCLES )
    ) clk_gen_i (
        .o_clk  ( clk ),
        .o_srst ( srst )
    );

    proxy_test_top #(
        .MEM_DEPTH    ( MEM_DEPTH ),
        .MEM_DATA_WID ( MEM_DATA_WID )
    ) dut_i (
        .clk       ( clk ),
        .srst      ( srst ),
        .i_psel    ( psel ),
        .i_penable ( penable ),
        .i_pwrite  ( pwrite ),
        .i_paddr   ( paddr ),
        .i_pwdata  ( pwdata ),
        .o_prdata  ( prdata ),
        .o_pready  ( pready ),
        .o_pslverr ( pslverr )
    );

    // --------------------
    // Helpers
    // --------------------
    function automatic logic [31:0] lfsr_step(input logic [31:0] state);
        if (state[0]) begin
            return (state >> 1) ^ LFSR_TAPS;
        end
        return state >> 1;
    endfunction

    // One LFSR step per bit taken
    task automatic rand_word(output logic [DATA_WID-1:0] word);
        word = '0;
        for (int b = 0; b < DATA_WID; b++) begin
            word = {word[DATA_WID-2:0], lfsr_state[0]};
            lfsr_state = lfsr_step(lfsr_state);
        end
    endtask

    function automatic logic [ADDR_WID-1:0] reg_ofs(input int ofs);
        return REG_BASE | ADDR_WID'(ofs);
    endfunction

    function automatic logic [ADDR_WID-1:0] mem_ofs(input int ofs);
        return MEM_BASE | ADDR_WID'(ofs);
    endfunction

    // Inner access command with bit 8 as write and the low bits as index
    function automatic logic [DATA_WID-1:0] inner_cmd(input bit wr, input int idx);
        return (wr ? INNER_WR : '0) | DATA_WID'(idx);
    endfunction

    task automatic add_write(input string name, input logic [ADDR_WID-1:0] addr,
                             input logic [DATA_WID-1:0] wdata, input bit exp_err);
        tests_q.push_back('{name: name, addr: addr, write: 1'b1, wdata: wdata,
                            chk_data: 1'b0, exp_rdata: '0, exp_err: exp_err});
    endtask

    task automatic add_read(input string name, input logic [ADDR_WID-1:0] addr,
                            input logic [DATA_WID-1:0] exp_rdata, input bit exp_err);
        tests_q.push_back('{name: name, addr: addr, write: 1'b0, wdata: '0,
                            chk_data: 1'b1, exp_rdata: exp_rdata, exp_err: exp_err});
    endtask

    task automatic compare_value(input string name, input logic [DATA_WID-1:0] expected,
                                 input logic [DATA_WID-1:0] actual);
        if (actual !== expected) begin
            $display("Fail %s: expected 0x%08h, actual 0x%08h", name, expected, actual);
            $display("Test failures found");
            $fatal(1, "Mismatch, run stopped");
        end
    endtask

    // APB setup phase followed by access until the target is ready
    task automatic apb_transfer(input logic [ADDR_WID-1:0] addr, input logic write,
                                input logic [DATA_WID-1:0] wdata,
                                output logic [DATA_WID-1:0] rdata, output logic err);
        psel    = 1'b1;
        penable = 1'b0;
        pwrite  = write;
        paddr   = addr;
        pwdata  = wdata;
        @(negedge clk);
        penable = 1'b1;
        do begin
            @(posedge clk);
        end while (!pready);
        rdata = prdata;
        err   = pslverr;
        @(negedge clk);
        psel    = 1'b0;
        penable = 1'b0;
    endtask

    task automatic run_test(input test_t t);
        logic [DATA_WID-1:0] rdata;
        logic                err;
        apb_transfer(t.addr, t.write, t.wdata, rdata, err);
        compare_value({t.name, " pslverr"}, DATA_WID'(t.exp_err), DATA_WID'(err));
        if (t.chk_data) begin
            compare_value(t.name, t.exp_rdata, rdata);
        end
    endtask

    // --------------------
    // Test table
    // --------------------
    task automatic build_tests();
        logic [DATA_WID-1:0] trig_val;
        logic [DATA_WID-1:0] scr_val;
        logic [DATA_WID-1:0] lo [N_WORDS];
        logic [DATA_WID-1:0] hi [N_WORDS];
        rand_word(trig_val);
        rand_word(scr_val);
        for (int i = 0; i < N_WORDS; i++) begin
            rand_word(lo[i]);
            rand_word(hi[i]);
        end
        // Identity words
        add_write("cmd rd pre", reg_ofs(proxy_pkg::REG_OFS_CMD),
                  inner_cmd(1'b0, proxy_pkg::IDX_PRE), 1'b0);
        add_read("rdata pre", reg_ofs(proxy_pkg::REG_OFS_RDATA), proxy_pkg::ID_PRE, 1'b0);
        add_write("cmd rd post", reg_ofs(proxy_pkg::REG_OFS_CMD),
                  inner_cmd(1'b0, proxy_pkg::IDX_POST), 1'b0);
        add_read("rdata post", reg_ofs(proxy_pkg::REG_OFS_RDATA), proxy_pkg::ID_POST, 1'b0);
        // Trigger write lands in the captured status
        add_write("wdata trig", reg_ofs(proxy_pkg::REG_OFS_WDATA), trig_val, 1'b0);
        add_write("cmd wr trig", reg_ofs(proxy_pkg::REG_OFS_CMD),
                  inner_cmd(1'b1, proxy_pkg::IDX_TRIGGER), 1'b0);
        add_write("cmd rd status", reg_ofs(proxy_pkg::REG_OFS_CMD),
                  inner_cmd(1'b0, proxy_pkg::IDX_STATUS), 1'b0);
        add_read("rdata status", reg_ofs(proxy_pkg::REG_OFS_RDATA), trig_val, 1'b0);
        // Sticky error on a write to a constant
        add_read("status clear", reg_ofs(proxy_pkg::REG_OFS_STATUS), 32'd0, 1'b0);
        add_write("cmd wr pre", reg_ofs(proxy_pkg::REG_OFS_CMD),
                  inner_cmd(1'b1, proxy_pkg::IDX_PRE), 1'b0);
        add_read("status sticky", reg_ofs(proxy_pkg::REG_OFS_STATUS), 32'd1, 1'b0);
        add_write("status wr", reg_ofs(proxy_pkg::REG_OFS_STATUS), 32'd0, 1'b0);
        add_read("status cleared", reg_ofs(proxy_pkg::REG_OFS_STATUS), 32'd0, 1'b0);
        add_write("wdata scratch", reg_ofs(proxy_pkg::REG_OFS_WDATA), scr_val, 1'b0);
        add_write("cmd wr scratch", reg_ofs(proxy_pkg::REG_OFS_CMD),
                  inner_cmd(1'b1, SCRATCH_IDX), 1'b0);
        add_write("cmd rd scratch", reg_ofs(proxy_pkg::REG_OFS_CMD),
                  inner_cmd(1'b0, SCRATCH_IDX), 1'b0);
        add_read("rdata scratch", reg_ofs(proxy_pkg::REG_OFS_RDATA), scr_val, 1'b0);
        // Memory writes to consecutive words
        add_write("mem addr", mem_ofs(proxy_pkg::MEM_OFS_ADDR), MEM_START, 1'b0);
        for (int i = 0; i < N_WORDS; i++) begin
            add_write("mem lo", mem_ofs(proxy_pkg::MEM_OFS_DATA_LO), lo[i], 1'b0);
            add_write("mem hi", mem_ofs(proxy_pkg::MEM_OFS_DATA_HI), hi[i], !HAS_HI);
            add_write("mem cmd wr", mem_ofs(proxy_pkg::MEM_OFS_CMD), MEM_CMD_WR, 1'b0);
        end
        add_read("mem addr inc", mem_ofs(proxy_pkg::MEM_OFS_ADDR), MEM_START + N_WORDS, 1'b0);
        // Read-back with each DATA read right behind its read command
        add_write("mem addr back", mem_ofs(proxy_pkg::MEM_OFS_ADDR), MEM_START, 1'b0);
        for (int i = 0; i < N_WORDS; i++) begin
            add_write("mem cmd rd", mem_ofs(proxy_pkg::MEM_OFS_CMD), MEM_CMD_RD, 1'b0);
            add_read("mem rd lo", mem_ofs(proxy_pkg::MEM_OFS_DATA_LO), lo[i], 1'b0);
            add_read("mem rd hi", mem_ofs(proxy_pkg::MEM_OFS_DATA_HI),
                     HAS_HI ? hi[i] : '0, !HAS_HI);
        end
        // Address wrap
        add_write("mem addr top", mem_ofs(proxy_pkg::MEM_OFS_ADDR), MEM_DEPTH - 1, 1'b0);
        add_write("mem cmd top", mem_ofs(proxy_pkg::MEM_OFS_CMD), MEM_CMD_WR, 1'b0);
        add_read("mem addr wrap", mem_ofs(proxy_pkg::MEM_OFS_ADDR), 32'd0, 1'b0);
        // Error responses
        add_read("region 2 rd", ADDR_WID'(2) << 10, 32'd0, 1'b1);
        add_write("region 3 wr", (ADDR_WID'(3) << 10) | 12'h004, 32'hFFFF_FFFF, 1'b1);
        add_read("reg bad ofs", reg_ofs('h10), 32'd0, 1'b1);
        add_read("mem bad ofs", mem_ofs('h14), 32'd0, 1'b1);
        add_write("mem cmd both", mem_ofs(proxy_pkg::MEM_OFS_CMD), 32'd3, 1'b1);
        add_read("mem addr kept", mem_ofs(proxy_pkg::MEM_OFS_ADDR), 32'd0, 1'b0);
    endtask

    initial begin
        psel       = 1'b0;
        penable    = 1'b0;
        pwrite     = 1'b0;
        paddr      = '0;
        pwdata     = '0;
        lfsr_state = LFSR_SEED;
        build_tests();
        cycle_limit = CYCLES_PER_TEST * tests_q.size() + RST_CYCLES;
        wait (!srst);
        @(negedge clk);
        foreach (tests_q[i]) begin
            run_test(tests_q[i]);
        end
        repeat (2) @(negedge clk);
        if (dut_i.props_i.fail_cnt == 0) begin
            $display("All tests passed!");
            $finish;
        end else begin
            $display("Test failures found");
            $fatal(1, "%0d assertion failures", dut_i.props_i.fail_cnt);
        end
    end

    // Stop at the first failed APB response assertion
    always @(posedge clk) begin
        if (dut_i.props_i.fail_cnt != 0) begin
            $display("An APB response assertion failed");
            $display("Test failures found");
            $fatal(1, "Assertion failure, run stopped");
        end
    end

    // Hang guard
    always @(posedge clk) begin
        cycle_cnt <= cycle_cnt + 1;
        if (cycle_limit != 0 && cycle_cnt >= cycle_limit) begin
            $display("Timeout after %0d cycles, the DUT stopped answering", cycle_cnt);
            $display("Test failures found");
            $fatal(1, "Run ended by the cycle limit");
        end
    end

endmodule : proxy_test_tb

//--- project.f
proxy_pkg.sv
proxy_bus_if.sv
proxy_apb_decoder.sv
reg_proxy.sv
mem_proxy.sv
proxy_test_top.sv
tb_clk_gen.sv
proxy_test_properties.sv
proxy_test_tb.sv

//--- Bender.yml
package:
  name: proxy_test

sources:
  # Design
  - files:
      - proxy_pkg.sv
      - proxy_bus_if.sv
      - proxy_apb_decoder.sv
      - reg_proxy.sv
      - mem_proxy.sv
      - proxy_test_top.sv

  # Testbench
  - target: test
    files:
      - tb_clk_gen.sv
      - proxy_test_properties.sv
      - proxy_test_tb.sv

# Top modules: proxy_test_tb for simulation, proxy_test_top for the design
# File order matches project.f
